//--- bench/tb_checker.sv
// Result monitor with reference model, expected-result queue and error counters
`timescale 1ns/1ps
`default_nettype none

module tb_checker import vmul_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    lat_chk_i,
  // DUT request port
  input  logic    in_valid_i,
  input  logic    in_ready_i,
  input  vew_e    sew_i,
  input  mul_op_e op_i,
  input  vxrm_e   vxrm_i,
  input  elen_t   a_i,
  input  elen_t   b_i,
  input  elen_t   c_i,
  input  strb_t   mask_i,
  // DUT result port
  input  logic    out_valid_i,
  input  logic    out_ready_i,
  input  elen_t   result_i,
  input  strb_t   out_mask_i,
  input  vxsat_t  vxsat_i,
  // Counters
  output int      checks_o,
  output int      errors_o,
  output int      pending_o,
  output int      full_seen_o
);

  typedef struct packed {
    elen_t       result;
    strb_t       mask;
    vxsat_t      vxsat;
    logic [31:0] cyc;
  } exp_t;

  exp_t exp_q[$];
  int   checks;
  int   errors;
  int   full_seen;
  int   cyc;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic void expected_result(input vew_e sew, input mul_op_e op,
                                          input vxrm_e rm, input elen_t a, input elen_t b,
                                          input elen_t c, output elen_t res,
                                          output vxsat_t sat);
    int                  sw;
    logic signed [129:0] one;
    logic signed [129:0] lo;
    logic signed [129:0] max_v;
    logic signed [129:0] x;
    logic signed [129:0] y;
    logic signed [129:0] z;
    logic signed [129:0] p;
    logic signed [129:0] q;
    logic                g;
    logic                s;
    logic                d;
    logic                inc;
    sw    = 8 << int'(sew);
    one   = 130'sd1;
    lo    = (one <<< sw) - one;
    max_v = (one <<< (sw - 1)) - one;
    res   = '0;
    sat   = '0;
    for (int l = 0; l < 64 / sw; l++) begin
      x = ($signed({66'd0, a}) >>> (l * sw)) & lo;
      y = ($signed({66'd0, b}) >>> (l * sw)) & lo;
      z = ($signed({66'd0, c}) >>> (l * sw)) & lo;
      if (op inside {VMULH, VSMUL} && x[sw-1]) begin
        x = x - (one <<< sw);
      end
      if (op inside {VMULH, VMULHSU, VSMUL} && y[sw-1]) begin
        y = y - (one <<< sw);
      end
      p = x * y;
      case (op)
        VMUL:                   q = p;
        VMULH, VMULHU, VMULHSU: q = p >>> sw;
        VSMUL: begin
          // Guard, sticky and lsb of the shifted product
          g = p[sw-2];
          s = |(p & ((one <<< (sw - 2)) - one));
          d = p[sw-1];
          case (rm)
            RNU:     inc = g;
            RNE:     inc = g & (s | d);
            ROD:     inc = ~d & (g | s);
            default: inc = 1'b0;
          endcase
          q = p >>> (sw - 1);
          q = inc ? q + one : q;
          if (q > max_v || q < -(one <<< (sw - 1))) begin
            q      = max_v;
            sat[l] = 1'b1;
          end
        end
        VMACC, VMADD:   q = z + p;
        VNMSAC, VNMSUB: q = z - p;
        default:        q = '0;
      endcase
      res = res | elen_t'((q & lo) << (l * sw));
    end
  endfunction

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////

  initial begin
    checks    = 0;
    errors    = 0;
    full_seen = 0;
    cyc       = 0;
  end

  always @(posedge clk_i) begin
    exp_t   e;
    elen_t  r;
    vxsat_t s;
    if (rst_n_i) begin
      cyc = cyc + 1;
      // Order FIFO is full here, so no request may be taken
      if (exp_q.size() == TagDepth) begin
        full_seen++;
        if (in_ready_i) begin
          $display("Error at %0t: ready_o high with %0d items in flight", $time, TagDepth);
          errors++;
        end
      end
      if (out_valid_i && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: result came out with no request pending", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          checks++;
          if (result_i !== e.result || out_mask_i !== e.mask || vxsat_i !== e.vxsat) begin
            $display("Mismatch at %0t: got result %h mask %h vxsat %h, expected %h %h %h",
                     $time, result_i, out_mask_i, vxsat_i, e.result, e.mask, e.vxsat);
            errors++;
          end
          if (lat_chk_i && cyc - e.cyc != 2) begin
            $display("Mismatch at %0t: latency %0d cycles, expected 2", $time, cyc - e.cyc);
            errors++;
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        expected_result(sew_i, op_i, vxrm_i, a_i, b_i, c_i, r, s);
        e.result = r;
        e.vxsat  = s;
        e.mask   = mask_i;
        e.cyc    = cyc;
        exp_q.push_back(e);
      end
    end
  end

  assign checks_o    = checks;
  assign errors_o    = errors;
  assign pending_o   = exp_q.size();
  assign full_seen_o = full_seen;

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
// Testbench clock source and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset low for 8 cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_vmul.sv
// Testbench top with DUT, clock source, monitor and the test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_vmul import vmul_pkg::*; ();

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  logic    in_ready;
  vew_e    sew;
  mul_op_e op;
  vxrm_e   vxrm;
  elen_t   opa;
  elen_t   opb;
  elen_t   opc;
  strb_t   mask;
  logic    out_valid;
  logic    out_ready;
  elen_t   result;
  strb_t   res_mask;
  vxsat_t  vxsat;

  integer  seed;
  logic    rand_ready;
  logic    lat_chk;
  int      checks;
  int      errors;
  int      pending;
  int      full_seen;
  int      tb_errors;
  int      timeouts;
  int      chk_mark;
  int      err_mark;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  vmul_unit u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .valid_i     (in_valid),
    .ready_o     (in_ready),
    .sew_i       (sew),
    .op_i        (op),
    .vxrm_i      (vxrm),
    .operand_a_i (opa),
    .operand_b_i (opb),
    .operand_c_i (opc),
    .mask_i      (mask),
    .valid_o     (out_valid),
    .ready_i     (out_ready),
    .result_o    (result),
    .mask_o      (res_mask),
    .vxsat_o     (vxsat)
  );

  tb_checker u_checker (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .lat_chk_i   (lat_chk),
    .in_valid_i  (in_valid),
    .in_ready_i  (in_ready),
    .sew_i       (sew),
    .op_i        (op),
    .vxrm_i      (vxrm),
    .a_i         (opa),
    .b_i         (opb),
    .c_i         (opc),
    .mask_i      (mask),
    .out_valid_i (out_valid),
    .out_ready_i (out_ready),
    .result_i    (result),
    .out_mask_i  (res_mask),
    .vxsat_i     (vxsat),
    .checks_o    (checks),
    .errors_o    (errors),
    .pending_o   (pending),
    .full_seen_o (full_seen)
  );

  // Result back-pressure that is random at 50% or held high
  always @(negedge clk) begin
    if (rand_ready) begin
      out_ready = 1'($random(seed));
    end else begin
      out_ready = 1'b1;
    end
  end

  // Hold one request on the inputs until ready_o takes it
  task automatic send_request(input vew_e w, input mul_op_e o, input vxrm_e r,
                              input elen_t x, input elen_t y, input elen_t z,
                              input strb_t m);
    int   waited;
    logic accepted;
    @(negedge clk);
    in_valid = 1'b1;
    sew      = w;
    op       = o;
    vxrm     = r;
    opa      = x;
    opb      = y;
    opc      = z;
    mask     = m;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < 100) begin
      @(posedge clk);
      accepted = in_ready;
      waited++;
    end
    if (!accepted) begin
      $display("Timeout at %0t: ready_o stayed low for 100 cycles", $time);
      timeouts++;
    end
  endtask

  task automatic send_random(input vew_e w);
    mul_op_e o;
    vxrm_e   r;
    elen_t   x;
    elen_t   y;
    elen_t   z;
    strb_t   m;
    o = mul_op_e'(4'($unsigned($random(seed)) % 9));
    r = vxrm_e'(2'($random(seed)));
    x = {$random(seed), $random(seed)};
    y = {$random(seed), $random(seed)};
    z = {$random(seed), $random(seed)};
    m = 8'($random(seed));
    send_request(w, o, r, x, y, z, m);
  endtask

  // Stop requesting and wait for every result still in flight
  task automatic drain_results();
    int waited;
    @(negedge clk);
    in_valid = 1'b0;
    waited   = 0;
    while (pending != 0 && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout at %0t: %0d results never came out", $time, pending);
      timeouts++;
    end
  endtask

  task automatic report_test(input string name);
    int all_err;
    all_err = errors + tb_errors + timeouts;
    $display("%s: %0d checks, %0d errors", name, checks - chk_mark, all_err - err_mark);
    chk_mark = checks;
    err_mark = all_err;
  endtask

  // Sets the sign bit or the whole of each lane on all lanes or even lanes only
  function automatic elen_t lane_pattern(input vew_e w, input logic even_only,
                                         input logic msb_only);
    int    sw;
    elen_t ones;
    elen_t pat;
    sw   = 8 << int'(w);
    ones = (elen_t'(1) << sw) - 1;
    pat  = '0;
    for (int l = 0; l < 64 / sw; l++) begin
      if (!even_only || l % 2 == 0) begin
        if (msb_only) begin
          pat[l*sw+sw-1] = 1'b1;
        end else begin
          pat = pat | (ones << (l * sw));
        end
      end
    end
    return pat;
  endfunction

  initial begin
    int    waited;
    elen_t rnd_a;
    elen_t rnd_b;
    elen_t rnd_c;
    seed       = 32'h5997b3c6;
    in_valid   = 1'b0;
    sew        = EW8;
    op         = VMUL;
    vxrm       = RNU;
    opa        = '0;
    opb        = '0;
    opc        = '0;
    mask       = '0;
    out_ready  = 1'b1;
    rand_ready = 1'b0;
    lat_chk    = 1'b0;
    tb_errors  = 0;
    timeouts   = 0;
    chk_mark   = 0;
    err_mark   = 0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout at %0t: reset was never released", $time);
      timeouts++;
    end

    ////////////////////////////////////////////////// Reset state
    @(negedge clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("Mismatch at %0t: after reset valid_o is %b and ready_o is %b, expected 0 and 1",
               $time, out_valid, in_ready);
      tb_errors++;
    end
    report_test("Test 1 reset state");

    ////////////////////////////////////////////////// Random, no stall
    lat_chk = 1'b1;
    for (int i = 0; i < 200; i++) begin
      send_random(vew_e'(2'($random(seed))));
    end
    drain_results();
    lat_chk = 1'b0;
    report_test("Test 2 random requests with ready_i high");

    ////////////////////////////////////////////////// Rounding and clamp
    for (int w = 0; w < 4; w++) begin
      for (int r = 0; r < 4; r++) begin
        rnd_b = {$random(seed), $random(seed)};
        rnd_c = {$random(seed), $random(seed)};
        // Most negative squared on even lanes clamps there only
        rnd_b = (rnd_b & ~lane_pattern(vew_e'(2'(w)), 1'b1, 1'b0)) |
                lane_pattern(vew_e'(2'(w)), 1'b1, 1'b1);
        send_request(vew_e'(2'(w)), VSMUL, vxrm_e'(2'(r)),
                     lane_pattern(vew_e'(2'(w)), 1'b0, 1'b1), rnd_b, rnd_c, 8'($random(seed)));
        rnd_a = {$random(seed), $random(seed)};
        rnd_b = {$random(seed), $random(seed)};
        send_request(vew_e'(2'(w)), VSMUL, vxrm_e'(2'(r)), rnd_a, rnd_b, rnd_c,
                     8'($random(seed)));
      end
    end
    drain_results();
    report_test("Test 3 VSMUL rounding and saturation");

    ////////////////////////////////////////////////// Back-pressure
    rand_ready = 1'b1;
    for (int i = 0; i < 200; i++) begin
      send_random(vew_e'(2'(i % 4)));
    end
    drain_results();
    if (full_seen == 0) begin
      $display("The order FIFO never held %0d items, back-pressure was not reached", TagDepth);
      tb_errors++;
    end
    report_test("Test 4 order under random back-pressure");

    ////////////////////////////////////////////////// Mask pass-through
    for (int i = 0; i < 16; i++) begin
      rnd_a = {$random(seed), $random(seed)};
      rnd_b = {$random(seed), $random(seed)};
      rnd_c = {$random(seed), $random(seed)};
      send_request(vew_e'(2'(i)), VMUL, RNU, rnd_a, rnd_b, rnd_c,
                   (i < 8) ? 8'(1 << i) : ~8'(1 << (i - 8)));
    end
    drain_results();
    rand_ready = 1'b0;
    report_test("Test 5 mask pass-through");

    $display("Summary: %0d checks, %0d errors, %0d timeouts",
             checks, errors + tb_errors, timeouts);
    if (errors + tb_errors + timeouts == 0 && checks > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
rtl/vmul_pkg.sv
rtl/mul_req_if.sv
rtl/mul_pipe.sv
rtl/simd_mul.sv
rtl/vmul_unit.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_vmul.sv

//--- rtl/mul_pipe.sv
// Elastic valid/ready register chain with configurable depth and generic payload
`timescale 1ns/1ps
`default_nettype none

module mul_pipe #(
  parameter int unsigned NumPipeRegs = 1,
  parameter type         payload_t   = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Index i is the input of stage i, index NumPipeRegs is the chain output
  payload_t             stage_data [NumPipeRegs+1];
  logic [NumPipeRegs:0] stage_valid;
  logic [NumPipeRegs:0] stage_ready;

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic     valid_q;
    payload_t data_q;

    // Load when downstream takes our item or we only hold a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i]) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_data[i+1]  = data_q;
    assign stage_valid[i+1] = valid_q;
  end

  // Ready ripples back combinationally from the output
  assign stage_ready[NumPipeRegs] = ready_i;
  assign ready_o                  = stage_ready[0];

  assign valid_o = stage_valid[NumPipeRegs];
  assign data_o  = stage_data[NumPipeRegs];

  // A stalled output item must be held until it is taken
  a_hold_stalled: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  ) else $error("mul_pipe output changed while stalled");

endmodule

`default_nettype wire

//--- rtl/mul_req_if.sv
// Multiply request bundle with valid/ready handshake and sender/multiplier modports
`timescale 1ns/1ps
`default_nettype none

interface mul_req_if import vmul_pkg::*; ();

  // Request payload
  elen_t   a;
  elen_t   b;
  elen_t   c;
  strb_t   mask;
  mul_op_e op;
  vxrm_e   vxrm;

  // Handshake that transfers when both are high
  logic    valid;
  logic    ready;

  // Request side owns everything but ready
  modport sender (
    output a, b, c, mask, op, vxrm, valid,
    input  ready
  );

  // Multiplier side
  modport multiplier (
    input  a, b, c, mask, op, vxrm, valid,
    output ready
  );

endinterface

`default_nettype wire

//--- rtl/simd_mul.sv
// Packed-SIMD multiplier for one element width with operand and result stages
`timescale 1ns/1ps
`default_nettype none

module simd_mul import vmul_pkg::*; #(
  parameter vew_e ElementWidth = EW64
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Request side
  mul_req_if.multiplier    req,
  // Result side
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output mul_res_t         res_o
);

  // Element width in bits and number of lanes per word
  localparam int unsigned Sew   = 8 << int'(ElementWidth);
  localparam int unsigned Lanes = ElenBits / Sew;

  //////////////////////////////////////////////////
  // Operand stage
  //////////////////////////////////////////////////

  mul_beat_t beat_in;
  mul_beat_t beat;
  logic      beat_valid;
  logic      beat_ready;

  assign beat_in = '{
    a:    req.a,
    b:    req.b,
    c:    req.c,
    mask: req.mask,
    op:   req.op,
    vxrm: req.vxrm
  };

  mul_pipe #(
    .NumPipeRegs (MulInRegs),
    .payload_t   (mul_beat_t)
  ) u_operand_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (req.valid),
    .ready_o (req.ready),
    .data_i  (beat_in),
    .valid_o (beat_valid),
    .ready_i (beat_ready),
    .data_o  (beat)
  );

  //////////////////////////////////////////////////
  // Lane arithmetic
  //////////////////////////////////////////////////

  logic signed_a;
  logic signed_b;

  // Sign extension of the operands depends on the flavour of multiply
  assign signed_a = beat.op inside {VMULH, VSMUL};
  assign signed_b = beat.op inside {VMULH, VMULHSU, VSMUL};

  elen_t            lane_result;
  logic [Lanes-1:0] lane_sat;

  for (genvar l = 0; l < Lanes; l++) begin : gen_lane
    logic [Sew-1:0]   a_l;
    logic [Sew-1:0]   b_l;
    logic [Sew-1:0]   c_l;
    logic [2*Sew-1:0] a_ext;
    logic [2*Sew-1:0] b_ext;
    logic [2*Sew-1:0] prod;
    logic             rnd_inc;
    logic [Sew+1:0]   rnd;
    logic             ovf;
    logic [Sew-1:0]   res_l;

    assign a_l = beat.a[l*Sew +: Sew];
    assign b_l = beat.b[l*Sew +: Sew];
    assign c_l = beat.c[l*Sew +: Sew];

    // Double-width product, exact for every sign combination
    assign a_ext = {{Sew{a_l[Sew-1] & signed_a}}, a_l};
    assign b_ext = {{Sew{b_l[Sew-1] & signed_b}}, b_l};
    assign prod  = a_ext * b_ext;

    // Rounding increment for the shift by SEW-1
    always_comb begin
      case (beat.vxrm)
        RNU:     rnd_inc = prod[Sew-2];
        RNE:     rnd_inc = prod[Sew-2] & ((|prod[Sew-3:0]) | prod[Sew-1]);
        RDN:     rnd_inc = 1'b0;
        ROD:     rnd_inc = ~prod[Sew-1] & (|prod[Sew-2:0]);
        default: rnd_inc = 1'b0;
      endcase
    end

    // Shifted product with one guard bit, then rounded
    assign rnd = {prod[2*Sew-1], prod[2*Sew-1:Sew-1]} + {{(Sew+1){1'b0}}, rnd_inc};

    // Only the positive side can leave the signed SEW-bit range
    assign ovf = rnd[Sew+1:Sew-1] != {3{rnd[Sew+1]}};

    always_comb begin
      case (beat.op)
        VMUL:                   res_l = prod[Sew-1:0];
        VMULH, VMULHU, VMULHSU: res_l = prod[2*Sew-1:Sew];
        VSMUL:                  res_l = ovf ? {1'b0, {(Sew-1){1'b1}}} : rnd[Sew-1:0];
        VMACC, VMADD:           res_l = c_l + prod[Sew-1:0];
        VNMSAC, VNMSUB:         res_l = c_l - prod[Sew-1:0];
        default:                res_l = '0;
      endcase
    end

    assign lane_result[l*Sew +: Sew] = res_l;
    assign lane_sat[l]               = (beat.op == VSMUL) & ovf;
  end

  //////////////////////////////////////////////////
  // Result stage
  //////////////////////////////////////////////////

  mul_res_t res_d;

  assign res_d = '{
    result: lane_result,
    mask:   beat.mask,
    vxsat:  vxsat_t'(lane_sat)
  };

  mul_pipe #(
    .NumPipeRegs (MulOutRegs),
    .payload_t   (mul_res_t)
  ) u_result_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (beat_valid),
    .ready_o (beat_ready),
    .data_i  (res_d),
    .valid_o (res_valid_o),
    .ready_i (res_ready_i),
    .data_o  (res_o)
  );

  // Sender must never hand over an undefined operation
  a_legal_op: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req.valid && req.ready |-> req.op inside {[VMUL:VNMSUB]}
  ) else $error("simd_mul accepted an illegal op");

endmodule

`default_nettype wire

//--- rtl/vmul_pkg.sv
// Shared types, enums, bundles and sizing constants of the SIMD multiply unit
`default_nettype none

package vmul_pkg;

  //////////////////////////////////////////////////
  // Sizing
  //////////////////////////////////////////////////

  // Width of one vector datapath word
  localparam int unsigned ElenBits = 64;
  // One mask bit per byte
  localparam int unsigned StrbBits = ElenBits / 8;
  // One multiplier per element width
  localparam int unsigned NumWidths = 4;

  // Operand stages inside each multiplier, and its single result stage
  localparam int unsigned MulInRegs  = 1;
  localparam int unsigned MulOutRegs = 1;

  // Order FIFO that remembers which multiplier owns each request
  localparam int unsigned TagDepth   = 4;
  localparam int unsigned TagPtrBits = $clog2(TagDepth);
  localparam int unsigned TagCntBits = TagPtrBits + 1;

  //////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////

  typedef logic [ElenBits-1:0] elen_t;
  typedef logic [StrbBits-1:0] strb_t;
  // Bit l flags lane l, unused upper bits stay zero
  typedef logic [StrbBits-1:0] vxsat_t;

  // Fixed-point rounding mode
  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

  // Element width, SEW = 8 << value
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Supported multiply operations
  typedef enum logic [3:0] {
    VMUL    = 4'd0,
    VMULH   = 4'd1,
    VMULHU  = 4'd2,
    VMULHSU = 4'd3,
    VSMUL   = 4'd4,
    VMACC   = 4'd5,
    VMADD   = 4'd6,
    VNMSAC  = 4'd7,
    VNMSUB  = 4'd8
  } mul_op_e;

  //////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////

  // Operand bundle held by the operand stages
  typedef struct packed {
    elen_t   a;
    elen_t   b;
    elen_t   c;
    strb_t   mask;
    mul_op_e op;
    vxrm_e   vxrm;
  } mul_beat_t;

  // Result bundle held by the result stage
  typedef struct packed {
    elen_t  result;
    strb_t  mask;
    vxsat_t vxsat;
  } mul_res_t;

endpackage

`default_nettype wire

//--- rtl/vmul_unit.sv
// Top level that steers requests to per-width multipliers and restores result order
`timescale 1ns/1ps
`default_nettype none

module vmul_unit import vmul_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Request side
  input  logic    valid_i,
  output logic    ready_o,
  input  vew_e    sew_i,
  input  mul_op_e op_i,
  input  vxrm_e   vxrm_i,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  elen_t   operand_c_i,
  input  strb_t   mask_i,
  // Result side
  output logic    valid_o,
  input  logic    ready_i,
  output elen_t   result_o,
  output strb_t   mask_o,
  output vxsat_t  vxsat_o
);

  //////////////////////////////////////////////////
  // Width-tag FIFO
  //////////////////////////////////////////////////

  vew_e                  tag_q [TagDepth];
  logic [TagPtrBits-1:0] wr_ptr_q;
  logic [TagPtrBits-1:0] rd_ptr_q;
  logic [TagCntBits-1:0] tag_cnt_q;
  logic                  tag_full;
  logic                  tag_empty;
  vew_e                  head_tag;
  logic                  push;
  logic                  pop;

  assign tag_full  = tag_cnt_q == TagCntBits'(TagDepth);
  assign tag_empty = tag_cnt_q == '0;
  assign head_tag  = tag_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      tag_cnt_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        tag_cnt_q <= tag_cnt_q + 1'b1;
      end else if (pop && !push) begin
        tag_cnt_q <= tag_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      tag_q[wr_ptr_q] <= sew_i;
    end
  end

  //////////////////////////////////////////////////
  // Multipliers
  //////////////////////////////////////////////////

  mul_req_if req_if [NumWidths] ();

  logic [NumWidths-1:0] mul_ready;
  logic [NumWidths-1:0] res_valid;
  logic [NumWidths-1:0] res_ready;
  mul_res_t             res [NumWidths];

  for (genvar w = 0; w < NumWidths; w++) begin : gen_width
    assign req_if[w].a     = operand_a_i;
    assign req_if[w].b     = operand_b_i;
    assign req_if[w].c     = operand_c_i;
    assign req_if[w].mask  = mask_i;
    assign req_if[w].op    = op_i;
    assign req_if[w].vxrm  = vxrm_i;
    // Only the addressed multiplier sees valid, and only with room for a tag
    assign req_if[w].valid = valid_i & ~tag_full & (sew_i == vew_e'(w));
    assign mul_ready[w]    = req_if[w].ready;

    // Results drain from the multiplier named at the FIFO head
    assign res_ready[w] = ready_i & (head_tag == vew_e'(w));

    simd_mul #(
      .ElementWidth (vew_e'(w))
    ) u_simd_mul (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req         (req_if[w]),
      .res_valid_o (res_valid[w]),
      .res_ready_i (res_ready[w]),
      .res_o       (res[w])
    );
  end

  assign ready_o = mul_ready[sew_i] & ~tag_full;
  assign push    = valid_i & ready_o;

  // Pop is taken from the multiplier handshakes themselves
  assign pop = |(res_valid & res_ready);

  assign valid_o  = ~tag_empty & res_valid[head_tag];
  assign result_o = res[head_tag].result;
  assign mask_o   = res[head_tag].mask;
  assign vxsat_o  = res[head_tag].vxsat;

  // A push into a full FIFO would carry the occupancy past the depth
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tag_cnt_q <= TagCntBits'(TagDepth)
  ) else $error("tag FIFO pushed while full");

  // Every result in a multiplier must own a tag
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop |-> !tag_empty
  ) else $error("tag FIFO popped while empty");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vmul -f list.f || exit 1
sim_out=$(./obj_dir/Vtb_vmul)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1
